//--- Bender.yml
package:
  name: ising_phase

sources:
  - include_dirs:
      - .
    files:
      - hw/ising_pkg.sv
      - hw/run_timer.sv
      - hw/anneal_ctrl.sv
      - hw/phase_sampler.sv
      - hw/phase_readout.sv
      - hw/ising_phase_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_ising_phase.sv

//--- hw/anneal_ctrl.sv
// Anneal run controller

`timescale 1ns/1ps
`default_nettype none

module anneal_ctrl
    import ising_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    input  run_cmd_t cmd,
    input  logic     last,
    output logic     load,
    output logic     count_en,
    output logic     busy,
    output run_cfg_t cfg,
    output run_len_t run_cycles
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;

    run_cfg_t    cfg_q;
    run_len_t    run_len_q;
    logic        cmd_fire;

    // a new command is taken before the first run and after each one
    assign cmd_ready = (state_q == IDLE) || (state_q == DONE);
    assign cmd_fire  = cmd_valid && cmd_ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (cmd_fire) begin
                    state_d = LOAD;
                end
            end
            LOAD: begin
                state_d = RUN;
            end
            RUN: begin
                if (last) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                if (cmd_fire) begin
                    state_d = LOAD;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // the configuration stays put after the run so readout can still
    // compare against the cutoff
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_q     <= '0;
            run_len_q <= '0;
        end else if (cmd_fire) begin
            cfg_q.counter_max    <= cmd.counter_max;
            cfg_q.counter_cutoff <= cmd.counter_cutoff;
            run_len_q            <= cmd.run_cycles;
        end
    end

    assign load       = (state_q == LOAD);
    assign count_en   = (state_q == RUN);
    assign busy       = (state_q == LOAD) || (state_q == RUN);
    assign cfg        = cfg_q;
    assign run_cycles = run_len_q;

endmodule

`default_nettype wire

//--- hw/ising_phase_top.sv
// Ising phase readout top

`timescale 1ns/1ps
`default_nettype none

`include "ising_config.svh"

module ising_phase_top
    import ising_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  spin_vec_t spins,
    input  spin_vec_t field,
    input  logic      cmd_valid,
    output logic      cmd_ready,
    input  run_cmd_t  cmd,
    input  logic      rd_valid,
    output logic      rd_ready,
    input  rd_addr_t  rd_addr,
    output logic      rsp_valid,
    input  logic      rsp_ready,
    output rd_rsp_t   rsp,
    output logic      busy
);

    logic                            load;
    logic                            count_en;
    logic                            last;
    run_cfg_t                        cfg;
    run_len_t                        run_cycles;
    phase_cnt_t [`ISING_N_SPINS-1:0] phase;

    anneal_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd        (cmd),
        .last       (last),
        .load       (load),
        .count_en   (count_en),
        .busy       (busy),
        .cfg        (cfg),
        .run_cycles (run_cycles)
    );

    run_timer u_timer (
        .clk        (clk),
        .rst        (rst),
        .load       (load),
        .run_cycles (run_cycles),
        .count_en   (count_en),
        .last       (last)
    );

    phase_sampler u_sampler (
        .clk      (clk),
        .rst      (rst),
        .spins    (spins),
        .field    (field),
        .load     (load),
        .count_en (count_en),
        .cfg      (cfg),
        .phase    (phase)
    );

    phase_readout u_readout (
        .clk       (clk),
        .rst       (rst),
        .busy      (busy),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_addr   (rd_addr),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .phase     (phase),
        .cfg       (cfg)
    );

endmodule

`default_nettype wire

//--- hw/ising_pkg.sv
// Ising phase readout types

`default_nettype none

`include "ising_config.svh"

package ising_pkg;

    // one bit per spin oscillator
    typedef logic [`ISING_N_SPINS-1:0] spin_vec_t;

    typedef logic [`ISING_CNT_W-1:0] phase_cnt_t;
    typedef logic [`ISING_RUN_W-1:0] run_len_t;
    typedef logic [`ISING_ADDR_W-1:0] rd_addr_t;

    // run command as sent by the host
    typedef struct packed {
        phase_cnt_t counter_max;
        phase_cnt_t counter_cutoff;
        run_len_t   run_cycles;
    } run_cmd_t;

    // part of the command that stays with the counters after the run
    typedef struct packed {
        phase_cnt_t counter_max;
        phase_cnt_t counter_cutoff;
    } run_cfg_t;

    // sign is set when the phase ended below the cutoff
    typedef struct packed {
        phase_cnt_t phase;
        logic       sign;
        logic       addr_err;
    } rd_rsp_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        RUN,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hw/phase_readout.sv
// Phase counter readout

`timescale 1ns/1ps
`default_nettype none

`include "ising_config.svh"

module phase_readout
    import ising_pkg::*;
(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            busy,
    input  logic                            rd_valid,
    output logic                            rd_ready,
    input  rd_addr_t                        rd_addr,
    output logic                            rsp_valid,
    input  logic                            rsp_ready,
    output rd_rsp_t                         rsp,
    input  phase_cnt_t [`ISING_N_SPINS-1:0] phase,
    input  run_cfg_t                        cfg
);

    rd_addr_t   offset;
    rd_addr_t   word_idx;
    logic       addr_err;
    phase_cnt_t sel_phase;
    logic       rd_fire;
    rd_rsp_t    rsp_q;
    logic       rsp_valid_q;

    // requests wait while a run is counting or a response is still out
    assign rd_ready = !busy && !rsp_valid_q;
    assign rd_fire  = rd_valid && rd_ready;

    assign offset   = rd_addr - `ISING_PHASE_BASE;
    assign word_idx = offset >> 2;

    assign addr_err = (rd_addr < `ISING_PHASE_BASE) ||
                      (rd_addr[1:0] != 2'b00) ||
                      (word_idx >= rd_addr_t'(`ISING_N_SPINS));

    always_comb begin
        sel_phase = '0;
        for (int i = 0; i < `ISING_N_SPINS; i++) begin
            if (!addr_err && word_idx == rd_addr_t'(i)) begin
                sel_phase = phase[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
        end else if (rd_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // the response only changes on a new request, which cannot arrive
    // while one is still pending
    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rsp_q.phase    <= sel_phase;
            rsp_q.sign     <= !addr_err && (sel_phase < cfg.counter_cutoff);
            rsp_q.addr_err <= addr_err;
        end
    end

    assign rsp_valid = rsp_valid_q;
    assign rsp       = rsp_q;

endmodule

`default_nettype wire

//--- hw/phase_sampler.sv
// Spin phase sampler

`timescale 1ns/1ps
`default_nettype none

`include "ising_config.svh"

module phase_sampler
    import ising_pkg::*;
(
    input  logic                                 clk,
    input  logic                                 rst,
    input  spin_vec_t                            spins,
    input  spin_vec_t                            field,
    input  logic                                 load,
    input  logic                                 count_en,
    input  run_cfg_t                             cfg,
    output phase_cnt_t [`ISING_N_SPINS-1:0]      phase
);

    // spin and field arrive from free running oscillators, so the
    // mismatch is resampled three times before the counters use it
    spin_vec_t mismatch_raw;
    spin_vec_t mismatch_s1;
    spin_vec_t mismatch_s2;
    spin_vec_t mismatch_s3;

    phase_cnt_t [`ISING_N_SPINS-1:0] cnt_q;

    assign mismatch_raw = spins ^ field;

    always_ff @(posedge clk) begin
        mismatch_s1 <= mismatch_raw;
        mismatch_s2 <= mismatch_s1;
        mismatch_s3 <= mismatch_s2;
    end

    // a mismatch pulls the counter toward zero, a match pushes it up to
    // counter_max, and both ends saturate
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (load) begin
            for (int i = 0; i < `ISING_N_SPINS; i++) begin
                cnt_q[i] <= cfg.counter_cutoff;
            end
        end else if (count_en) begin
            for (int i = 0; i < `ISING_N_SPINS; i++) begin
                if (mismatch_s3[i]) begin
                    if (cnt_q[i] != '0) begin
                        cnt_q[i] <= cnt_q[i] - 1'b1;
                    end
                end else begin
                    // a cutoff already at or above the ceiling just holds
                    if (cnt_q[i] < cfg.counter_max) begin
                        cnt_q[i] <= cnt_q[i] + 1'b1;
                    end
                end
            end
        end
    end

    assign phase = cnt_q;

endmodule

`default_nettype wire

//--- hw/run_timer.sv
// Run length timer

`timescale 1ns/1ps
`default_nettype none

module run_timer
    import ising_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     load,
    input  run_len_t run_cycles,
    input  logic     count_en,
    output logic     last
);

    // counted cycles still left in the current run
    run_len_t remain_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            remain_q <= '0;
        end else if (load) begin
            remain_q <= run_cycles;
        end else if (count_en && remain_q != '0) begin
            remain_q <= remain_q - 1'b1;
        end
    end

    // flagged one count early so the controller leaves RUN on the edge
    // that performs the final update
    assign last = count_en && (remain_q == run_len_t'(1));

endmodule

`default_nettype wire

//--- ising_config.svh
// Ising phase readout configuration

`ifndef ISING_CONFIG_SVH
`define ISING_CONFIG_SVH

// number of spin oscillators sampled by the readout
`define ISING_N_SPINS 8

// width of one saturating phase counter
`define ISING_CNT_W 16

// width of the run length, counted in clock cycles
`define ISING_RUN_W 20

// width of the byte address on the read channel
`define ISING_ADDR_W 12

// counter 0 sits at this byte address and the others follow one word apart
`define ISING_PHASE_BASE 12'h100

`endif

//--- sources.f
+incdir+.
hw/ising_pkg.sv
hw/run_timer.sv
hw/anneal_ctrl.sv
hw/phase_sampler.sv
hw/phase_readout.sv
hw/ising_phase_top.sv
tests/tb_clock_gen.sv
tests/tb_ising_phase.sv

//--- tests/ising_phase_trace.txt
# C max cutoff run_cycles spins field | R addr phase sign addr_err | M as R, issued mid-run
# W waits for the run to end | B max random rsp_ready stall in cycles | all numbers hex
R 100 0000 0 0
R 11c 0000 0 0
C 0100 0080 000040 a5 0f
W
R 100 00c0 0 0
R 104 0040 1 0
R 118 00c0 0 0
R 11c 0040 1 0
C 0030 0020 000050 3c 00
M 10c 0000 1 0
W
R 100 0030 0 0
R 110 0000 1 0
C 0010 0040 000008 ff f0
W
R 100 0038 1 0
R 11c 0040 0 0
R 0fc 0000 0 1
R 102 0000 0 1
R 120 0000 0 1
B 5
C ffff 0005 000010 55 00
W
R 100 0000 1 0
R 104 0015 0 0
R 118 0000 1 0
R 11c 0015 0 0
C ffff 1234 000001 01 00
W
R 100 1233 1 0
R 104 1235 0 0

//--- tests/tb_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // reset covers the first 16 rising edges and drops on a falling edge
    initial begin
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- tests/tb_ising_phase.sv
// Ising phase readout testbench

`timescale 1ns/1ps
`default_nettype none

module tb_ising_phase
    import ising_pkg::*;
();

    localparam int TIMEOUT = 1000;

    logic      clk;
    logic      rst;
    spin_vec_t spins;
    spin_vec_t field;
    logic      cmd_valid;
    logic      cmd_ready;
    run_cmd_t  cmd;
    logic      rd_valid;
    logic      rd_ready;
    rd_addr_t  rd_addr;
    logic      rsp_valid;
    logic      rsp_ready;
    rd_rsp_t   rsp;
    logic      busy;

    integer    seed;
    integer    fd;
    int        value_errors;
    int        other_errors;
    int        busy_len;
    int        max_stall;
    run_len_t  last_run;
    logic      aborted;

    tb_clock_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    ising_phase_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .spins     (spins),
        .field     (field),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .cmd       (cmd),
        .rd_valid  (rd_valid),
        .rd_ready  (rd_ready),
        .rd_addr   (rd_addr),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .busy      (busy)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0h, got %0h",
                     $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic finish_run();
        $display("value errors: %0d, other failures: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic abort_run(input string reason);
        $display("%0t: %s", $time, reason);
        other_errors++;
        aborted = 1'b1;
    endtask

    // cycles spent busy since the last accepted command
    always @(posedge clk) begin
        if (rst || (cmd_valid && cmd_ready)) begin
            busy_len <= 0;
        end else if (busy) begin
            busy_len <= busy_len + 1;
        end
    end

    // neither channel may accept anything while a run is going
    always @(negedge clk) begin
        if (!rst && busy) begin
            check_value("cmd_ready", 0, cmd_ready);
            check_value("rd_ready", 0, rd_ready);
        end
    end

    task automatic send_cmd(input run_cmd_t c, input spin_vec_t s, input spin_vec_t f);
        int n;
        @(negedge clk);
        spins = s;
        field = f;
        // give the mismatch time to pass the three synchronizer stages
        repeat (5) @(negedge clk);
        cmd = c;
        cmd_valid = 1'b1;
        n = 0;
        while (!cmd_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!cmd_ready) begin
            abort_run("the run command was never accepted");
        end else begin
            @(negedge clk);
            cmd_valid = 1'b0;
            last_run = c.run_cycles;
            check_value("busy", 1, busy);
        end
    endtask

    task automatic wait_run_end();
        int n;
        n = 0;
        while (busy && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (busy) begin
            abort_run("the run did not finish in time");
        end else begin
            // one LOAD cycle comes ahead of the counted cycles
            check_value("busy cycles", last_run + 1, busy_len);
            check_value("cmd_ready", 1, cmd_ready);
        end
    endtask

    task automatic read_and_check(input rd_addr_t a, input rd_rsp_t exp, input logic mid_run);
        int n;
        int stall;
        @(negedge clk);
        if (mid_run) begin
            check_value("busy at mid-run read", 1, busy);
        end
        rd_addr = a;
        rd_valid = 1'b1;
        n = 0;
        while (!rd_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rd_ready) begin
            abort_run("the read request was never accepted");
        end else begin
            check_value("busy", 0, busy);
            @(negedge clk);
            rd_valid = 1'b0;
            // another address on the idle request lines must not reach the response
            rd_addr = ~a;
            check_value("rsp_valid", 1, rsp_valid);
            check_value("rd_ready", 0, rd_ready);
            check_value("rsp.phase", exp.phase, rsp.phase);
            check_value("rsp.sign", exp.sign, rsp.sign);
            check_value("rsp.addr_err", exp.addr_err, rsp.addr_err);
            stall = $unsigned($random(seed)) % (max_stall + 1);
            repeat (stall) begin
                @(negedge clk);
                check_value("rsp_valid", 1, rsp_valid);
                check_value("rd_ready", 0, rd_ready);
                check_value("rsp", exp, rsp);
            end
            rsp_ready = 1'b1;
            @(negedge clk);
            rsp_ready = 1'b0;
            check_value("rsp_valid", 0, rsp_valid);
        end
    endtask

    initial begin : main
        logic [7:0]    kind;
        logic [1023:0] skip_line;
        logic [31:0]   v0;
        logic [31:0]   v1;
        logic [31:0]   v2;
        logic [31:0]   v3;
        logic [31:0]   v4;
        run_cmd_t      c;
        rd_rsp_t       e;
        int            r;
        int            n;
        seed = 32'headd;
        spins = '0;
        field = '0;
        cmd_valid = 1'b0;
        cmd = '0;
        rd_valid = 1'b0;
        rd_addr = '0;
        rsp_ready = 1'b0;
        value_errors = 0;
        other_errors = 0;
        max_stall = 0;
        last_run = '0;
        aborted = 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rst && n < TIMEOUT);
        if (rst) begin
            abort_run("reset never went low");
        end
        if (!aborted) begin
            @(negedge clk);
            check_value("cmd_ready", 1, cmd_ready);
            check_value("rd_ready", 1, rd_ready);
            check_value("busy", 0, busy);
            check_value("rsp_valid", 0, rsp_valid);
            fd = $fopen("tests/ising_phase_trace.txt", "r");
            if (fd == 0) begin
                abort_run("cannot open the trace file tests/ising_phase_trace.txt");
            end
        end

        if (!aborted) begin
            r = $fscanf(fd, " %c", kind);
            while (r == 1 && !aborted) begin
                case (kind)
                    "#": begin
                        r = $fgets(skip_line, fd);
                    end
                    "B": begin
                        r = $fscanf(fd, "%h", v0);
                        max_stall = v0;
                    end
                    "C": begin
                        r = $fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4);
                        c.counter_max = phase_cnt_t'(v0);
                        c.counter_cutoff = phase_cnt_t'(v1);
                        c.run_cycles = run_len_t'(v2);
                        send_cmd(c, spin_vec_t'(v3), spin_vec_t'(v4));
                    end
                    "W": begin
                        wait_run_end();
                    end
                    "R", "M": begin
                        r = $fscanf(fd, "%h %h %h %h", v0, v1, v2, v3);
                        e.phase = phase_cnt_t'(v1);
                        e.sign = v2[0];
                        e.addr_err = v3[0];
                        read_and_check(rd_addr_t'(v0), e, kind == "M");
                    end
                    default: begin
                        abort_run("the trace holds a line of unknown type");
                    end
                endcase
                r = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
        end
        finish_run();
    end

endmodule

`default_nettype wire
